//--- Makefile
# Verilator build for the I2C master

VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = i2cMasterTb
RTL_TOP    = i2cMaster
FILELIST   = src.f
LOG        = sim.log
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/i2cClockUnit.sv
/* free-running bit-phase divider, one pulse each for the first, data and final
   quarter boundaries of a bus bit */
`timescale 1ns/1ps

module i2cClockUnit
    import i2cPkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic firstCycle,
    output logic dataCycle,
    output logic finalCycle
);

    localparam int PERIOD = 4 * QUARTER;    // clk cycles per bus bit

    phaseT phase;

    // ----------------------------------------------------------
    // phase counter, wraps once per bus bit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= '0;
        end else if (phase == phaseT'(PERIOD - 1)) begin
            phase <= '0;                    // start of next bit
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // phase decode
    //   0          SCL low, SDA may move
    //   QUARTER    SCL released by the engine shortly before this
    //   2*QUARTER  middle of SCL high, sample point
    //   3*QUARTER  SCL pulled low again

    assign firstCycle = (phase == phaseT'(0));
    assign dataCycle  = (phase == phaseT'(2 * QUARTER));   // sample point
    assign finalCycle = (phase == phaseT'(3 * QUARTER));   // scl falls

endmodule

//--- rtl/i2cCore.sv
/* register layer between host port and bit engine, with command, transmit and
   receive registers and the ready and valid handshake flags */
`timescale 1ns/1ps

module i2cCore
    import i2cPkg::*;
    #(parameter LINES = 1) (
    input  logic             clk,
    input  logic             reset,
    input  i2cCommand        commandIn,
    input  byteT             transmitDataIn,
    input  logic             transmitAckIn,
    input  logic             transmitDataLoadEn,   // host command strobe
    input  logic             receiveDataReadReq,   // host read of the data register
    output byteT             receiveData,
    output logic             receiveAck,
    output logic             receiveValid,
    output logic             transmitReady,
    inout  wire  [LINES-1:0] scl,
    inout  wire  [LINES-1:0] sda
);

    logic      firstCycle;
    logic      dataCycle;
    logic      finalCycle;
    logic      transmitValid;
    logic      unitReady;          // engine done pulse
    logic      unitValid;          // engine result pulse
    byteT      unitData;
    logic      unitAck;
    i2cCommand command;
    byteT      transmitData;
    logic      transmitAck;

    assign transmitValid = ~transmitReady;  // command pending for the engine

    // ----------------------------------------------------------
    // command side registers

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            command     <= CMD_START;
            transmitAck <= 1'b1;            // nack by default
        end else if (transmitDataLoadEn) begin
            command     <= commandIn;
            transmitAck <= transmitAckIn;
        end
    end

    always_ff @(posedge clk) begin
        if (transmitDataLoadEn)
            transmitData <= transmitDataIn;
    end

    // ----------------------------------------------------------
    // result registers, overwritten by every new result

    always_ff @(posedge clk) begin
        if (unitValid)
            receiveData <= unitData;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            receiveAck <= 1'b1;
        else if (unitValid)
            receiveAck <= unitAck;
    end

    // ----------------------------------------------------------
    // handshake flags

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            receiveValid <= 1'b0;
        else if (unitValid)
            receiveValid <= 1'b1;           // new byte beats a read in the same cycle
        else if (receiveDataReadReq)
            receiveValid <= 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            transmitReady <= 1'b1;
        else if (transmitDataLoadEn)
            transmitReady <= 1'b0;          // command taken
        else if (unitReady)
            transmitReady <= 1'b1;          // engine finished it
    end

    // host may only load a command while the previous one is finished
    loadOnlyWhenReady: assert property (@(posedge clk) disable iff (reset)
        transmitDataLoadEn |-> transmitReady);

    // ----------------------------------------------------------
    // engine and phase generator

    i2cUnit #(.LINES(LINES)) i2cUnit (
        .clk,
        .reset,
        .command,
        .transmitData,
        .transmitAck,
        .firstCycle,
        .dataCycle,
        .finalCycle,
        .transmitValid,
        .receiveData   (unitData),
        .receiveAck    (unitAck),
        .transmitReady (unitReady),
        .receiveValid  (unitValid),
        .busy          (),
        .scl,
        .sda
    );

    i2cClockUnit i2cClockUnit (
        .clk,
        .reset,
        .firstCycle,
        .dataCycle,
        .finalCycle
    );

endmodule

//--- rtl/i2cHostPort.sv
/* host register port, turns register writes and reads into core strobes
   and returns registered read data */
`timescale 1ns/1ps

module i2cHostPort
    import i2cPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hostWrite,
    input  logic      hostRead,
    input  regAddrT   hostAddr,
    input  byteT      hostWriteData,
    output byteT      hostReadData,
    input  byteT      receiveData,
    input  logic      receiveAck,
    input  logic      receiveValid,
    input  logic      transmitReady,
    output i2cCommand commandIn,
    output byteT      transmitDataIn,
    output logic      transmitAckIn,
    output logic      transmitDataLoadEn,
    output logic      receiveDataReadReq
);

    byteT holdData;             // last byte written to the data register
    byteT statusByte;

    // ----------------------------------------------------------
    // write side

    always_ff @(posedge clk) begin
        if (hostWrite && hostAddr == ADDR_DATA)
            holdData <= hostWriteData;
    end

    // control write goes straight through so the core reacts next edge
    assign transmitDataLoadEn = hostWrite && (hostAddr == ADDR_CTRL);
    assign commandIn          = i2cCommand'(hostWriteData[CTRL_CMD_LSB +: 2]);
    assign transmitAckIn      = hostWriteData[CTRL_ACK_BIT];
    assign transmitDataIn     = holdData;

    // ----------------------------------------------------------
    // read side

    assign receiveDataReadReq = hostRead && (hostAddr == ADDR_DATA);

    always_comb begin
        statusByte                 = '0;
        statusByte[STAT_READY_BIT] = transmitReady;
        statusByte[STAT_VALID_BIT] = receiveValid;
        statusByte[STAT_ACK_BIT]   = receiveAck;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            hostReadData <= '0;
        else if (hostRead)
            hostReadData <= (hostAddr == ADDR_DATA) ? receiveData : statusByte;
    end

endmodule

//--- rtl/i2cMaster.sv
/* top level of the byte-level I2C master, host register port plus core */
`timescale 1ns/1ps

module i2cMaster
    import i2cPkg::*;
    #(parameter LINES = 1) (
    input  logic             clk,
    input  logic             reset,
    input  logic             hostWrite,
    input  logic             hostRead,
    input  regAddrT          hostAddr,
    input  byteT             hostWriteData,
    output byteT             hostReadData,
    inout  wire  [LINES-1:0] scl,          // needs external pull-ups
    inout  wire  [LINES-1:0] sda
);

    // host port to core
    i2cCommand commandIn;
    byteT      transmitDataIn;
    logic      transmitAckIn;
    logic      transmitDataLoadEn;
    logic      receiveDataReadReq;
    // core to host port
    byteT      receiveData;
    logic      receiveAck;
    logic      receiveValid;
    logic      transmitReady;

    i2cHostPort hostPort (
        .clk, .reset, .hostWrite, .hostRead, .hostAddr, .hostWriteData, .hostReadData,
        .receiveData, .receiveAck, .receiveValid, .transmitReady,
        .commandIn, .transmitDataIn, .transmitAckIn, .transmitDataLoadEn,
        .receiveDataReadReq
    );

    i2cCore #(.LINES(LINES)) core (
        .clk, .reset, .commandIn, .transmitDataIn, .transmitAckIn,
        .transmitDataLoadEn, .receiveDataReadReq,
        .receiveData, .receiveAck, .receiveValid, .transmitReady,
        .scl, .sda
    );

endmodule

//--- rtl/i2cPkg.sv
/* shared widths, register map bit positions, command and engine state encodings
   for the byte-level I2C master */

package i2cPkg;

    // ----------------------------------------------------------
    // bus timing

    localparam int QUARTER = 4;                     // clk cycles per quarter bus bit
    localparam int PHASE_W = $clog2(4 * QUARTER);   // phase counter width

    // ----------------------------------------------------------
    // vector types

    typedef logic [7:0]         byteT;      // data byte on host side and bus
    typedef logic [0:0]         regAddrT;   // host register address
    typedef logic [PHASE_W-1:0] phaseT;     // position inside one bus bit

    // host register map
    localparam regAddrT ADDR_DATA = 1'b0;   // transmit hold / received byte
    localparam regAddrT ADDR_CTRL = 1'b1;   // command write, status read

    // control write layout
    localparam int CTRL_CMD_LSB = 0;        // two command bits from here
    localparam int CTRL_ACK_BIT = 2;        // ack bit driven after a READ

    // status read layout
    localparam int STAT_READY_BIT = 0;      // core can take a command
    localparam int STAT_VALID_BIT = 1;      // unread result present
    localparam int STAT_ACK_BIT   = 2;      // ack seen in the ninth bit

    // ----------------------------------------------------------
    // encodings

    typedef enum logic [1:0] {
        CMD_START = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2,
        CMD_STOP  = 2'd3
    } i2cCommand;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_BIT,     // eight data bits
        ST_ACK,     // ninth bit
        ST_STOP
    } i2cState;

endpackage

//--- rtl/i2cUnit.sv
/* bit and byte engine, runs START, WRITE, READ and STOP on open-drain SCL/SDA
   and returns the received byte and acknowledge bit */
`timescale 1ns/1ps

module i2cUnit
    import i2cPkg::*;
    #(parameter LINES = 1) (
    input  logic             clk,
    input  logic             reset,
    input  i2cCommand        command,
    input  byteT             transmitData,
    input  logic             transmitAck,      // ack driven in ninth bit of a READ
    input  logic             firstCycle,
    input  logic             dataCycle,
    input  logic             finalCycle,
    input  logic             transmitValid,    // a command is waiting
    output byteT             receiveData,
    output logic             receiveAck,
    output logic             transmitReady,    // one-cycle done pulse
    output logic             receiveValid,     // one-cycle result pulse
    output logic             busy,
    inout  wire  [LINES-1:0] scl,
    inout  wire  [LINES-1:0] sda
);

    i2cState    state;
    byteT       shiftReg;       // out on MSB, in on LSB
    logic [2:0] bitCount;
    logic       sclLow;         // 1 pulls every SCL wire low
    logic       sdaLow;         // 1 pulls every SDA wire low
    logic       riseNext;       // firstCycle one clk later
    logic       sdaIn;
    logic       startCmd;

    // ----------------------------------------------------------
    // open-drain pads

    assign scl   = sclLow ? {LINES{1'b0}} : {LINES{1'bz}};
    assign sda   = sdaLow ? {LINES{1'b0}} : {LINES{1'bz}};
    assign sdaIn = &sda;                    // any low wire makes the line low

    assign busy        = (state != ST_IDLE);
    assign receiveData = shiftReg;
    assign startCmd    = (state == ST_IDLE) && transmitValid && firstCycle;

    // shift register, loaded at command start and fed from the bus at each sample
    always_ff @(posedge clk) begin
        if (startCmd) begin
            // a read shifts out all ones so SDA stays released
            shiftReg <= (command == CMD_WRITE) ? transmitData : 8'hFF;
        end else if (state == ST_BIT && dataCycle) begin
            shiftReg <= {shiftReg[6:0], sdaIn};
        end
    end

    // ----------------------------------------------------------
    // bus state machine

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            bitCount      <= '0;
            sclLow        <= 1'b0;          // bus released
            sdaLow        <= 1'b0;
            riseNext      <= 1'b0;
            receiveAck    <= 1'b1;
            transmitReady <= 1'b0;
            receiveValid  <= 1'b0;
        end else begin
            riseNext      <= firstCycle;
            transmitReady <= 1'b0;          // pulses by default low
            receiveValid  <= 1'b0;

            // scl goes high one clk after sda has settled
            if (riseNext && state != ST_IDLE)
                sclLow <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (startCmd) begin
                        bitCount <= '0;
                        case (command)
                            CMD_START: begin
                                state  <= ST_START;
                                sdaLow <= 1'b0;     // release first, for repeated start
                            end
                            CMD_STOP: begin
                                state  <= ST_STOP;
                                sdaLow <= 1'b1;     // low before scl rises
                            end
                            CMD_WRITE: begin
                                state  <= ST_BIT;
                                sdaLow <= ~transmitData[7];
                            end
                            default: begin
                                state  <= ST_BIT;
                                sdaLow <= 1'b0;     // slave drives the data
                            end
                        endcase
                    end
                end

                ST_START: begin
                    if (dataCycle)
                        sdaLow <= 1'b1;             // sda falls with scl high
                    if (finalCycle) begin
                        sclLow        <= 1'b1;      // hold the bus
                        transmitReady <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end

                ST_BIT: begin
                    if (firstCycle)
                        sdaLow <= ~shiftReg[7];
                    if (finalCycle) begin
                        sclLow   <= 1'b1;
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7)
                            state <= ST_ACK;
                    end
                end

                ST_ACK: begin
                    // master acks only on a read, otherwise the slave answers
                    if (firstCycle)
                        sdaLow <= (command == CMD_READ) && !transmitAck;
                    if (dataCycle)
                        receiveAck <= sdaIn;
                    if (finalCycle) begin
                        sclLow        <= 1'b1;
                        transmitReady <= 1'b1;
                        receiveValid  <= 1'b1;
                        state         <= ST_IDLE;
                    end
                end

                ST_STOP: begin
                    if (dataCycle)
                        sdaLow <= 1'b0;             // sda rises with scl high
                    if (finalCycle) begin
                        transmitReady <= 1'b1;      // scl stays released, bus idle
                        state         <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // data and ack bits may only move while the master holds SCL low
    sdaStableWhileSclHigh: assert property (@(posedge clk) disable iff (reset)
        (state inside {ST_BIT, ST_ACK}) && $changed(sdaLow) |-> sclLow);

endmodule

//--- src.f
rtl/i2cPkg.sv
rtl/i2cClockUnit.sv
rtl/i2cUnit.sv
rtl/i2cCore.sv
rtl/i2cHostPort.sv
rtl/i2cMaster.sv
tb/i2cSlaveModel.sv
tb/i2cChecker.sv
tb/i2cMasterTb.sv

//--- tb/i2cChecker.sv
/* bus and host read monitor, decodes START, STOP and bits and compares each
   finished row with its expected values */
`timescale 1ns/1ps

module i2cChecker
    import i2cPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    hostRead,
    input  regAddrT hostAddr,
    input  byteT    hostReadData,
    input  wire     scl,
    input  wire     sda
);

    int         errorCount;
    int         failedRows;
    int         rowCount;
    int         rowFails;
    int         startCount;     // START conditions seen so far
    int         stopCount;
    int         startMark;      // counts at the end of the previous row
    int         stopMark;
    byteT       busByte;        // last eight bits sampled on SCL rise
    logic       ninth;
    logic [3:0] bitCnt;
    logic       sclQ;
    logic       sdaQ;
    logic       readPending;
    regAddrT    readAddr;
    byteT       statPrev;       // status before the data read
    byteT       statLast;
    byteT       dataLast;

    initial begin
        errorCount = 0;
        failedRows = 0;
        rowCount   = 0;
        startCount = 0;
        stopCount  = 0;
        startMark  = 0;
        stopMark   = 0;
        sclQ       = 1'b1;
        sdaQ       = 1'b1;
    end

    // ----------------------------------------------------------
    // bus decode

    always @(scl or sda or reset) begin
        if (reset) begin
            bitCnt = 4'd0;
        end else if (scl === 1'b1 && sclQ === 1'b1 && sdaQ === 1'b1 && sda === 1'b0) begin
            startCount = startCount + 1;
            bitCnt     = 4'd0;
        end else if (scl === 1'b1 && sclQ === 1'b1 && sdaQ === 1'b0 && sda === 1'b1) begin
            stopCount = stopCount + 1;
        end else if (sclQ === 1'b0 && scl === 1'b1) begin
            if (bitCnt < 4'd8)
                busByte = {busByte[6:0], sda};
            else
                ninth = sda;                        // acknowledge bit
            bitCnt = (bitCnt == 4'd8) ? 4'd0 : bitCnt + 4'd1;
        end
        sclQ = scl;
        sdaQ = sda;
    end

    // host read data is valid one cycle after the strobe
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            readPending <= 1'b0;
        end else begin
            readPending <= hostRead;
            readAddr    <= hostAddr;
            if (readPending && readAddr == ADDR_CTRL) begin
                statPrev <= statLast;
                statLast <= hostReadData;
            end else if (readPending) begin
                dataLast <= hostReadData;
            end
        end
    end

    // ----------------------------------------------------------
    // comparison helpers

    task automatic flagMismatch(string what, int got, int expected);
        $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        errorCount = errorCount + 1;
        rowFails   = rowFails + 1;
    endtask

    task automatic flagMissing(string what);
        $display("at %0t ns the bus never showed %s", $time, what);
        errorCount = errorCount + 1;
        rowFails   = rowFails + 1;
    endtask

    // state right after reset, from the last status read
    task automatic checkIdle();
        rowFails = 0;
        if (statLast[STAT_READY_BIT] !== 1'b1)
            flagMismatch("transmitReady after reset", statLast[STAT_READY_BIT], 1);
        if (statLast[STAT_VALID_BIT] !== 1'b0)
            flagMismatch("receiveValid after reset", statLast[STAT_VALID_BIT], 0);
        if (scl !== 1'b1 || sda !== 1'b1)
            flagMismatch("idle bus {scl,sda}", {scl, sda}, 3);
        $display("reset check %s", (rowFails == 0) ? "ok" : "failed");
        rowCount = rowCount + 1;
        if (rowFails != 0)
            failedRows = failedRows + 1;
    endtask

    // one stimulus row has finished, compare bus and host reads
    task automatic endRow(int row, i2cCommand cmd, byteT expByte, logic expAck);
        rowFails = 0;
        case (cmd)
            CMD_START: begin
                if (startCount == startMark)
                    flagMissing("a START condition");
            end
            CMD_STOP: begin
                if (stopCount == stopMark)
                    flagMissing("a STOP condition");
                if (scl !== 1'b1 || sda !== 1'b1)
                    flagMismatch("bus after STOP {scl,sda}", {scl, sda}, 3);
            end
            default: begin
                if (busByte !== expByte)
                    flagMismatch("byte on the bus", busByte, expByte);
                if (ninth !== expAck)
                    flagMismatch("ninth bit on the bus", ninth, expAck);
                if (statPrev[STAT_VALID_BIT] !== 1'b1)
                    flagMismatch("receiveValid after the command", statPrev[STAT_VALID_BIT], 1);
                if (statPrev[STAT_ACK_BIT] !== expAck)
                    flagMismatch("receiveAck", statPrev[STAT_ACK_BIT], expAck);
                if (dataLast !== expByte)
                    flagMismatch("received byte", dataLast, expByte);
                if (statLast[STAT_VALID_BIT] !== 1'b0)
                    flagMismatch("receiveValid after data read", statLast[STAT_VALID_BIT], 0);
            end
        endcase
        startMark = startCount;
        stopMark  = stopCount;
        rowCount  = rowCount + 1;
        if (rowFails != 0)
            failedRows = failedRows + 1;
        $display("row %0d %s %s", row, cmd.name(), (rowFails == 0) ? "ok" : "failed");
    endtask

endmodule

//--- tb/i2cMasterTb.sv
/* testbench top, clock, reset, pull-ups, stimulus table and host access loop */
`timescale 1ns/1ps

module i2cMasterTb
    import i2cPkg::*;
();

    localparam int MAX_ROWS  = 48;
    localparam int MAX_POLLS = 12 * 4 * QUARTER;    // well above one 9-bit command

    logic      clk;
    logic      reset;
    logic      hostWrite;
    logic      hostRead;
    regAddrT   hostAddr;
    byteT      hostWriteData;
    byteT      hostReadData;
    logic      readMode;
    tri1 [0:0] scl;             // pull-ups
    tri1 [0:0] sda;

    // stimulus table of command, data, ack to send, expected byte and expected ack
    i2cCommand cmdTab[MAX_ROWS];
    byteT      dataTab[MAX_ROWS];
    logic      ackTab[MAX_ROWS];
    byteT      expTab[MAX_ROWS];
    logic      expAckTab[MAX_ROWS];
    int        rows;
    integer    seed;
    byteT      status;
    byteT      ctrl;
    byteT      randByte;
    logic      timedOut;

    i2cMaster #(.LINES(1)) UUT (
        .clk, .reset, .hostWrite, .hostRead, .hostAddr, .hostWriteData, .hostReadData,
        .scl, .sda
    );

    i2cSlaveModel slave (.reset, .readMode, .scl(scl[0]), .sda(sda[0]));

    i2cChecker busCheck (
        .clk, .reset, .hostRead, .hostAddr, .hostReadData, .scl(scl[0]), .sda(sda[0])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------
    // host access tasks that move inputs on the falling edge

    task automatic writeReg(regAddrT addr, byteT data);
        @(negedge clk);
        hostWrite     = 1'b1;
        hostAddr      = addr;
        hostWriteData = data;
        @(negedge clk);
        hostWrite     = 1'b0;
    endtask

    task automatic readReg(regAddrT addr, output byteT data);
        @(negedge clk);
        hostRead = 1'b1;
        hostAddr = addr;
        @(negedge clk);
        hostRead = 1'b0;
        data     = hostReadData;
    endtask

    task automatic waitReady(output logic ok);
        byteT st;
        int   polls;
        ok    = 1'b0;
        polls = 0;
        while (!ok && polls < MAX_POLLS) begin
            readReg(ADDR_CTRL, st);
            ok    = st[STAT_READY_BIT];
            polls = polls + 1;
        end
    endtask

    task automatic addRow(i2cCommand cmd, byteT data, logic ack, byteT expByte, logic expAck);
        cmdTab[rows]    = cmd;
        dataTab[rows]   = data;
        ackTab[rows]    = ack;
        expTab[rows]    = expByte;
        expAckTab[rows] = expAck;
        rows            = rows + 1;
    endtask

    // ----------------------------------------------------------
    // main sequence

    initial begin
        reset         = 1'b1;
        hostWrite     = 1'b0;
        hostRead      = 1'b0;
        hostAddr      = ADDR_DATA;
        hostWriteData = 8'h00;
        readMode      = 1'b0;
        timedOut      = 1'b0;
        rows          = 0;
        seed          = 32'hb65cd3b1;

        // directed rows where a read returns the inverse of the last write
        addRow(CMD_START, 8'h00, 1'b1, 8'h00, 1'b0);
        addRow(CMD_WRITE, 8'hA6, 1'b1, 8'hA6, 1'b0);
        addRow(CMD_WRITE, 8'h3C, 1'b1, 8'h3C, 1'b0);
        addRow(CMD_READ,  8'h00, 1'b1, 8'hC3, 1'b1);
        addRow(CMD_STOP,  8'h00, 1'b1, 8'h00, 1'b0);
        addRow(CMD_START, 8'h00, 1'b1, 8'h00, 1'b0);
        for (int i = 0; i < 16; i++) begin
            randByte = byteT'($random(seed));
            addRow(CMD_WRITE, randByte, 1'b1, randByte, 1'b0);
            // slave releases the ninth bit so the master's own ack shows on the bus
            addRow(CMD_READ, 8'h00, i[0], ~randByte, i[0]);     // even rows ack, odd rows nack
        end
        addRow(CMD_STOP, 8'h00, 1'b1, 8'h00, 1'b0);

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        readReg(ADDR_CTRL, status);
        @(negedge clk);
        busCheck.checkIdle();

        for (int i = 0; i < rows && !timedOut; i++) begin
            @(negedge clk);
            readMode = (cmdTab[i] == CMD_READ);     // SCL is low between commands
            writeReg(ADDR_DATA, dataTab[i]);
            ctrl                         = 8'h00;
            ctrl[CTRL_CMD_LSB +: 2]      = cmdTab[i];
            ctrl[CTRL_ACK_BIT]           = ackTab[i];
            writeReg(ADDR_CTRL, ctrl);
            waitReady(status[STAT_READY_BIT]);
            if (!status[STAT_READY_BIT]) begin
                $display("row %0d: transmitReady never came back high", i);
                timedOut = 1'b1;
            end else begin
                readReg(ADDR_CTRL, status);
                readReg(ADDR_DATA, status);
                readReg(ADDR_CTRL, status);
                @(negedge clk);                     // let the checker take the last read
                busCheck.endRow(i, cmdTab[i], expTab[i], expAckTab[i]);
            end
        end

        $display("tests %0d, failed %0d, errors %0d",
                 busCheck.rowCount, busCheck.failedRows, busCheck.errorCount);
        if (timedOut || busCheck.errorCount != 0)
            $display("Simulation failed");
        else
            $display("Simulation passed");
        $finish;
    end

endmodule

//--- tb/i2cSlaveModel.sv
/* behavioral I2C slave, acks written bytes and answers reads with the
   inverse of the last byte written */
`timescale 1ns/1ps

module i2cSlaveModel
    import i2cPkg::*;
(
    input  logic reset,
    input  logic readMode,      // next byte on the bus is read by the master
    input  wire  scl,
    inout  wire  sda
);

    byteT       lastWritten;    // last byte the master wrote
    byteT       shiftIn;
    byteT       answer;
    logic [3:0] bitIdx;         // 0..7 data, 8 ack, 9 between START and first bit
    logic       active;         // inside a transfer
    logic       sclQ;
    logic       sdaQ;
    logic       slaveLow;

    assign answer = ~lastWritten;
    assign sda    = slaveLow ? 1'b0 : 1'bz;   // open drain, pulled up in the testbench

    // what the slave puts on SDA for the current bit
    always_comb begin
        slaveLow = 1'b0;
        if (active && bitIdx < 4'd8)
            slaveLow = readMode && !answer[~bitIdx[2:0]];  // MSB first
        else if (active && bitIdx == 4'd8)
            slaveLow = !readMode;                         // ack a written byte
    end

    // ----------------------------------------------------------
    // bus event decode

    always @(scl or sda or reset) begin
        if (reset) begin
            active      = 1'b0;
            bitIdx      = 4'd9;
            shiftIn     = 8'h00;
            lastWritten = 8'h00;
        end else if (scl === 1'b1 && sclQ === 1'b1 && sdaQ === 1'b1 && sda === 1'b0) begin
            active = 1'b1;                              // START
            bitIdx = 4'd9;
        end else if (scl === 1'b1 && sclQ === 1'b1 && sdaQ === 1'b0 && sda === 1'b1) begin
            active = 1'b0;                              // STOP
            bitIdx = 4'd9;
        end else if (sclQ === 1'b0 && scl === 1'b1) begin
            // rising edge, take a data bit of a written byte
            if (active && bitIdx < 4'd8 && !readMode)
                shiftIn = {shiftIn[6:0], sda};
        end else if (sclQ === 1'b1 && scl === 1'b0 && active) begin
            if (bitIdx == 4'd7 && !readMode)
                lastWritten = shiftIn;                  // byte complete
            bitIdx = (bitIdx >= 4'd8) ? 4'd0 : bitIdx + 4'd1;
        end
        sclQ = scl;
        sdaQ = sda;
    end

    initial begin
        sclQ = 1'b1;
        sdaQ = 1'b1;
    end

endmodule
